// ==== hw/fpu_lane_pkg.sv ====
// shared widths, opcodes, control register bits and bus records for the fpu lane
// every lane module refers to these through fpu_lane_pkg:: scoped names
package fpu_lane_pkg;

  localparam int num_buses = 4;
  localparam int bus_idx_w = $clog2(num_buses);
  localparam int data_w = 64;

  typedef logic [data_w-1:0] data_t;
  typedef logic [5:0] tag_t;
  typedef logic [2:0] bus_sel_t;
  typedef logic [3:0] flags_t;
  typedef logic [7:0] fp_csr_t;

  // select code with no bus behind it
  localparam bus_sel_t fwd_none = 3'd7;

  // compare flag positions within flags_t
  localparam int flag_gt = 0;
  localparam int flag_eq = 1;
  localparam int flag_lt = 2;
  localparam int flag_uno = 3;

  // fault enables in the control register
  localparam int csr_inv_en = 0;
  localparam int csr_den_en = 1;

  typedef enum logic [3:0] {
    op_cmp_d  = 4'd0,
    op_cmp_s  = 4'd1,
    op_copy_a = 4'd2,
    op_swap_s = 4'd3,
    op_dup_s  = 4'd4,
    op_and    = 4'd5,
    op_or     = 4'd6,
    op_xor    = 4'd7,
    op_andn   = 4'd8
  } fpu_op_e;

  typedef enum logic [1:0] {
    cause_invalid  = 2'd1,
    cause_denormal = 2'd2
  } cause_e;

  typedef struct packed {
    logic    en;
    fpu_op_e op;
    logic    ord;
    tag_t    tag;
  } fpu_issue_t;

  typedef struct packed {
    bus_sel_t fwd;
    bus_sel_t fwd_d;
  } fwd_ctl_t;

  typedef struct packed {
    logic    valid;
    fpu_op_e op;
    logic    ord;
    tag_t    tag;
    data_t   a;
    data_t   b;
    fp_csr_t csr;
  } fpu_stage_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    data_t data;
  } fpu_result_t;

  typedef struct packed {
    logic   en;
    tag_t   tag;
    cause_e cause;
  } fpu_ret_t;

  // compare ops own the flag result and the fault path
  function automatic logic is_cmp(fpu_op_e op);
    return (op == op_cmp_d) || (op == op_cmp_s);
  endfunction

endpackage

// ==== hw/operand_forward.sv ====
// source operand bypass for one fpu lane operand
// picks a result bus this cycle, a result bus from last cycle, or the register value
`timescale 1ns/1ns

module operand_forward (
  input  logic                                             clk,
  input  logic                                             rst,
  input  fpu_lane_pkg::data_t                              reg_val,
  input  fpu_lane_pkg::data_t [fpu_lane_pkg::num_buses-1:0] res_bus,
  input  fpu_lane_pkg::fwd_ctl_t                           sel,
  output fpu_lane_pkg::data_t                              operand
);

  // one-cycle-old copy of every bus
  fpu_lane_pkg::data_t [fpu_lane_pkg::num_buses-1:0] bus_d;

  always_ff @(posedge clk) begin
    bus_d <= res_bus;
  end

  // current bus wins over the delayed one
  always_comb begin
    if (sel.fwd < fpu_lane_pkg::num_buses) begin
      operand = res_bus[sel.fwd[fpu_lane_pkg::bus_idx_w-1:0]];
    end else if (sel.fwd_d < fpu_lane_pkg::num_buses) begin
      operand = bus_d[sel.fwd_d[fpu_lane_pkg::bus_idx_w-1:0]];
    end else begin
      operand = reg_val;
    end
  end

  // codes between the last bus and fwd_none are not issued by the scheduler
  sel_legal: assert property (@(posedge clk) disable iff (rst)
    (sel.fwd < fpu_lane_pkg::num_buses || sel.fwd == fpu_lane_pkg::fwd_none) &&
    (sel.fwd_d < fpu_lane_pkg::num_buses || sel.fwd_d == fpu_lane_pkg::fwd_none))
    else $error("illegal forward select %h", sel);

endmodule

// ==== hw/fpu_op_decode.sv ====
// stage-1 register of the fpu lane
// captures the issued op with its forwarded operands and the control register
// the units downstream decode their controls from the registered opcode
`timescale 1ns/1ns

module fpu_op_decode (
  input  logic                     clk,
  input  logic                     rst,
  input  fpu_lane_pkg::fpu_issue_t issue,
  input  fpu_lane_pkg::data_t      a,
  input  fpu_lane_pkg::data_t      b,
  input  fpu_lane_pkg::fp_csr_t    csr,
  output fpu_lane_pkg::fpu_stage_t stage
);

  always_ff @(posedge clk) begin
    if (rst) begin
      stage.valid <= 1'b0;
    end else begin
      stage.valid <= issue.en;
    end

    // payload only moves on issue, idle cycles keep the last op
    if (issue.en) begin
      stage.op  <= issue.op;
      stage.ord <= issue.ord;
      stage.tag <= issue.tag;
      stage.a   <= a;
      stage.b   <= b;
      stage.csr <= csr;
    end
  end

  // a valid stage always holds the op issued one cycle before, tag included
  valid_from_issue: assert property (@(posedge clk) disable iff (rst)
    stage.valid |-> $past(issue.en) && stage.tag == $past(issue.tag))
    else $error("stage valid without a matching issue");

endmodule

// ==== hw/fp_compare.sv ====
// stage-2 compare unit of the fpu lane
// orders A against B as doubles, or as the low singles for op_cmp_s
// also reports NaN and denormal inputs for the fault stage
`timescale 1ns/1ns

module fp_compare (
  input  fpu_lane_pkg::fpu_stage_t stage,
  output fpu_lane_pkg::flags_t     flags,
  output logic                     nan,
  output logic                     denorm
);

  typedef struct packed {
    logic        sign;
    logic [62:0] mag;
    logic        nan;
    logic        den;
  } fp_class_t;

  // single layout sits in bits 31:0, magnitude zero-extended
  function automatic fp_class_t classify(fpu_lane_pkg::data_t v, logic sgl);
    fp_class_t c;
    if (sgl) begin
      c.sign = v[31];
      c.mag  = {32'b0, v[30:0]};
      c.nan  = (&v[30:23]) && (|v[22:0]);
      c.den  = (~|v[30:23]) && (|v[22:0]);
    end else begin
      c.sign = v[63];
      c.mag  = v[62:0];
      c.nan  = (&v[62:52]) && (|v[51:0]);
      c.den  = (~|v[62:52]) && (|v[51:0]);
    end
    return c;
  endfunction

  logic      sgl;
  fp_class_t ca;
  fp_class_t cb;
  logic      both_zero;
  logic      a_lt;

  assign sgl = (stage.op == fpu_lane_pkg::op_cmp_s);
  assign ca = classify(stage.a, sgl);
  assign cb = classify(stage.b, sgl);
  assign nan = ca.nan | cb.nan;
  assign denorm = ca.den | cb.den;

  // +0 and -0 are equal
  assign both_zero = (ca.mag == '0) && (cb.mag == '0);
  // magnitude order flips for negatives
  assign a_lt = (ca.sign != cb.sign) ? ca.sign :
                (ca.sign ? (ca.mag > cb.mag) : (ca.mag < cb.mag));

  always_comb begin
    flags = '0;
    if (nan) begin
      flags[fpu_lane_pkg::flag_uno] = 1'b1;
    end else if (both_zero || (ca.sign == cb.sign && ca.mag == cb.mag)) begin
      flags[fpu_lane_pkg::flag_eq] = 1'b1;
    end else if (a_lt) begin
      flags[fpu_lane_pkg::flag_lt] = 1'b1;
    end else begin
      flags[fpu_lane_pkg::flag_gt] = 1'b1;
    end
  end

endmodule

// ==== hw/fp_perm_logic.sv ====
// stage-2 permute and bitwise logic unit of the fpu lane
// single moves act on the two 32-bit halves of B, logic ops combine A and B
`timescale 1ns/1ns

module fp_perm_logic (
  input  fpu_lane_pkg::fpu_stage_t stage,
  output fpu_lane_pkg::data_t      data
);

  always_comb begin
    case (stage.op)
      fpu_lane_pkg::op_copy_a: begin
        data = stage.a;
      end
      fpu_lane_pkg::op_swap_s: begin
        data = {stage.b[31:0], stage.b[63:32]};
      end
      // low single into both halves
      fpu_lane_pkg::op_dup_s: begin
        data = {stage.b[31:0], stage.b[31:0]};
      end
      fpu_lane_pkg::op_and: begin
        data = stage.a & stage.b;
      end
      fpu_lane_pkg::op_or: begin
        data = stage.a | stage.b;
      end
      fpu_lane_pkg::op_xor: begin
        data = stage.a ^ stage.b;
      end
      fpu_lane_pkg::op_andn: begin
        data = stage.a & ~stage.b;
      end
      // compares take the flag word at the top level
      default: begin
        data = '0;
      end
    endcase
  end

endmodule

// ==== hw/fpu_except.sv ====
// stage-2 fault stage of the fpu lane
// raises compare faults from ord and the operand classes and encodes the retire cause
// invalid outranks denormal and only the winning fault's csr enable decides ret.en
`timescale 1ns/1ns

module fpu_except (
  input  logic                     clk,
  input  logic                     rst,
  input  fpu_lane_pkg::fpu_stage_t stage,
  input  logic                     nan,
  input  logic                     denorm,
  output fpu_lane_pkg::fpu_ret_t   ret
);

  logic cmp_op;
  logic inv_fault;
  logic den_fault;
  logic fault_en;

  assign cmp_op = stage.valid && fpu_lane_pkg::is_cmp(stage.op);
  // unordered compares only fault on NaN when ord is set
  assign inv_fault = cmp_op && stage.ord && nan;
  assign den_fault = cmp_op && denorm;
  // the enable of a losing denormal fault is never consulted
  assign fault_en = inv_fault ? stage.csr[fpu_lane_pkg::csr_inv_en] :
                    (den_fault && stage.csr[fpu_lane_pkg::csr_den_en]);

  always_ff @(posedge clk) begin
    if (rst) begin
      ret.en <= 1'b0;
    end else begin
      ret.en <= fault_en;
    end
    ret.tag   <= stage.tag;
    ret.cause <= inv_fault ? fpu_lane_pkg::cause_invalid : fpu_lane_pkg::cause_denormal;
  end

  // a retire fault always belongs to an op that was in stage 2
  ret_needs_stage: assert property (@(posedge clk) disable iff (rst)
    !$past(stage.valid) |-> !ret.en)
    else $error("retire fault without a valid op");

endmodule

// ==== hw/fpu_lane.sv ====
// top of one fpu lane
// forwards both operands, registers the op, runs compare or permute and logic,
// and returns the result and any retire fault two cycles after issue
`timescale 1ns/1ns

module fpu_lane (
  input  logic                                             clk,
  input  logic                                             rst,
  input  fpu_lane_pkg::fpu_issue_t                         issue,
  input  fpu_lane_pkg::data_t                              reg_a,
  input  fpu_lane_pkg::data_t                              reg_b,
  input  fpu_lane_pkg::fwd_ctl_t                           fwd_a,
  input  fpu_lane_pkg::fwd_ctl_t                           fwd_b,
  input  fpu_lane_pkg::data_t [fpu_lane_pkg::num_buses-1:0] res_bus,
  input  fpu_lane_pkg::fp_csr_t                            csr,
  output fpu_lane_pkg::fpu_result_t                        result,
  output fpu_lane_pkg::fpu_ret_t                           ret
);

  fpu_lane_pkg::data_t      opnd_a;
  fpu_lane_pkg::data_t      opnd_b;
  fpu_lane_pkg::fpu_stage_t stage;
  fpu_lane_pkg::flags_t     flags;
  logic                     nan;
  logic                     denorm;
  fpu_lane_pkg::data_t      perm_data;
  fpu_lane_pkg::data_t      out_data;

  operand_forward u_fwd_a (
    .clk(clk), .rst(rst), .reg_val(reg_a), .res_bus(res_bus), .sel(fwd_a), .operand(opnd_a)
  );

  operand_forward u_fwd_b (
    .clk(clk), .rst(rst), .reg_val(reg_b), .res_bus(res_bus), .sel(fwd_b), .operand(opnd_b)
  );

  fpu_op_decode u_decode (
    .clk(clk), .rst(rst), .issue(issue), .a(opnd_a), .b(opnd_b), .csr(csr), .stage(stage)
  );

  fp_compare u_cmp (.stage(stage), .flags(flags), .nan(nan), .denorm(denorm));

  fp_perm_logic u_perm (.stage(stage), .data(perm_data));

  fpu_except u_except (
    .clk(clk), .rst(rst), .stage(stage), .nan(nan), .denorm(denorm), .ret(ret)
  );

  // flag word sits in the low bits, upper bits zero
  assign out_data = fpu_lane_pkg::is_cmp(stage.op) ?
    {{(fpu_lane_pkg::data_w - $bits(fpu_lane_pkg::flags_t)){1'b0}}, flags} : perm_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= stage.valid;
    end
    result.tag  <= stage.tag;
    result.data <= out_data;
  end

endmodule

// ==== dv/fpu_lane_tb.sv ====
// testbench for one fpu lane
// drives biased xorshift stimulus, predicts result and ret from the lane rules
// and checks each op exactly two cycles after issue
`timescale 1ns/1ns

module fpu_lane_tb;

  localparam int reset_cycles = 8;
  localparam int num_ops = 2000;
  localparam int drain_cycles = 20;
  localparam int max_cycles = reset_cycles + num_ops + drain_cycles;

  logic                                               clk;
  logic                                               rst;
  fpu_lane_pkg::fpu_issue_t                           issue;
  fpu_lane_pkg::data_t                                reg_a;
  fpu_lane_pkg::data_t                                reg_b;
  fpu_lane_pkg::fwd_ctl_t                             fwd_a;
  fpu_lane_pkg::fwd_ctl_t                             fwd_b;
  fpu_lane_pkg::data_t [fpu_lane_pkg::num_buses-1:0] res_bus;
  fpu_lane_pkg::data_t [fpu_lane_pkg::num_buses-1:0] prev_bus;
  fpu_lane_pkg::fp_csr_t                              csr;
  fpu_lane_pkg::fpu_result_t                          result;
  fpu_lane_pkg::fpu_ret_t                             ret;

  logic [63:0] rng_state = 64'd65;
  int res_errs;
  int ret_errs;
  int cycle_cnt;
  fpu_lane_pkg::fpu_result_t exp_res_q[$];
  fpu_lane_pkg::fpu_ret_t    exp_ret_q[$];

  fpu_lane DUT (
    .clk(clk), .rst(rst), .issue(issue), .reg_a(reg_a), .reg_b(reg_b), .fwd_a(fwd_a),
    .fwd_b(fwd_b), .res_bus(res_bus), .csr(csr), .result(result), .ret(ret)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [63:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  // NaN, zero and denormal patterns for doubles and for the low single
  function automatic fpu_lane_pkg::data_t pick_operand();
    logic [63:0] r;
    logic [63:0] m;
    r = xorshift();
    m = xorshift();
    case (r[2:0])
      3'd0: return {r[63], 11'h7ff, m[51:1], 1'b1};
      3'd1: return {r[63], 63'b0};
      3'd2: return {r[63], 11'h000, m[51:1], 1'b1};
      3'd3: return {m[63:32], r[31], 8'hff, m[22:1], 1'b1};
      3'd4: return {m[63:32], r[31], 31'b0};
      3'd5: return {m[63:32], r[31], 8'h00, m[22:1], 1'b1};
      default: return m;
    endcase
  endfunction

  function automatic fpu_lane_pkg::bus_sel_t pick_sel(logic [2:0] r);
    return r[2] ? fpu_lane_pkg::fwd_none : {1'b0, r[1:0]};
  endfunction

  task automatic drive_inputs(input logic live);
    logic [63:0] r;
    logic [15:0] op_idx;
    int k;
    r = xorshift();
    op_idx = r[15:0] % 16'd9;
    issue.en = live && (r[17:16] != 2'b00);
    issue.op = fpu_lane_pkg::fpu_op_e'(op_idx[3:0]);
    issue.ord = r[18];
    issue.tag = r[24:19];
    fwd_a.fwd = pick_sel(r[27:25]);
    fwd_a.fwd_d = pick_sel(r[30:28]);
    fwd_b.fwd = pick_sel(r[33:31]);
    fwd_b.fwd_d = pick_sel(r[36:34]);
    csr = r[44:37];
    reg_a = pick_operand();
    reg_b = pick_operand();
    // same source on both sides gives equal operands
    if (r[47:45] == 3'b000) begin
      reg_b = reg_a;
      fwd_b = fwd_a;
    end
    for (k = 0; k < fpu_lane_pkg::num_buses; k++) begin
      res_bus[k] = pick_operand();
    end
  endtask

  function automatic fpu_lane_pkg::data_t model_operand(fpu_lane_pkg::data_t reg_val,
                                                        fpu_lane_pkg::fwd_ctl_t sel);
    if (sel.fwd != fpu_lane_pkg::fwd_none) return res_bus[int'(sel.fwd)];
    if (sel.fwd_d != fpu_lane_pkg::fwd_none) return prev_bus[int'(sel.fwd_d)];
    return reg_val;
  endfunction

  task automatic split_fp(input fpu_lane_pkg::data_t v, input logic sgl, output logic sgn,
                          output logic [62:0] mag, output logic is_nan, output logic is_den);
    if (sgl) begin
      sgn = v[31];
      mag = {32'b0, v[30:0]};
      is_nan = (v[30:23] == 8'hff) && (v[22:0] != 23'b0);
      is_den = (v[30:23] == 8'h00) && (v[22:0] != 23'b0);
    end else begin
      sgn = v[63];
      mag = v[62:0];
      is_nan = (v[62:52] == 11'h7ff) && (v[51:0] != 52'b0);
      is_den = (v[62:52] == 11'h000) && (v[51:0] != 52'b0);
    end
  endtask

  // signed magnitude as a signed integer so both zeros land on 0
  function automatic logic signed [64:0] order_key(logic sgn, logic [62:0] mag);
    return sgn ? -$signed({2'b00, mag}) : $signed({2'b00, mag});
  endfunction

  task automatic predict();
    fpu_lane_pkg::data_t a;
    fpu_lane_pkg::data_t b;
    fpu_lane_pkg::fpu_result_t er;
    fpu_lane_pkg::fpu_ret_t et;
    logic sa, sb, na, nb, da, db;
    logic [62:0] ma, mb;
    logic [3:0] fl;
    a = model_operand(reg_a, fwd_a);
    b = model_operand(reg_b, fwd_b);
    er = '0;
    et = '0;
    er.valid = issue.en;
    er.tag = issue.tag;
    et.tag = issue.tag;
    case (issue.op)
      fpu_lane_pkg::op_cmp_d, fpu_lane_pkg::op_cmp_s: begin
        split_fp(a, issue.op == fpu_lane_pkg::op_cmp_s, sa, ma, na, da);
        split_fp(b, issue.op == fpu_lane_pkg::op_cmp_s, sb, mb, nb, db);
        // flags are {unordered, less, equal, greater}
        if (na || nb) fl = 4'b1000;
        else if (order_key(sa, ma) < order_key(sb, mb)) fl = 4'b0100;
        else if (order_key(sa, ma) == order_key(sb, mb)) fl = 4'b0010;
        else fl = 4'b0001;
        er.data = {60'b0, fl};
        // invalid outranks denormal and only the winner's enable bit counts
        if (issue.ord && (na || nb)) begin
          et.cause = fpu_lane_pkg::cause_invalid;
          et.en = issue.en && csr[fpu_lane_pkg::csr_inv_en];
        end else if (da || db) begin
          et.cause = fpu_lane_pkg::cause_denormal;
          et.en = issue.en && csr[fpu_lane_pkg::csr_den_en];
        end
      end
      fpu_lane_pkg::op_copy_a: er.data = a;
      fpu_lane_pkg::op_swap_s: er.data = {b[31:0], b[63:32]};
      fpu_lane_pkg::op_dup_s:  er.data = {b[31:0], b[31:0]};
      fpu_lane_pkg::op_and:    er.data = a & b;
      fpu_lane_pkg::op_or:     er.data = a | b;
      fpu_lane_pkg::op_xor:    er.data = a ^ b;
      fpu_lane_pkg::op_andn:   er.data = a & ~b;
      default:                 er.data = '0;
    endcase
    exp_res_q.push_back(er);
    exp_ret_q.push_back(et);
  endtask

  // idle slots only check that nothing comes out
  task automatic check_result(input fpu_lane_pkg::fpu_result_t exp,
                              input fpu_lane_pkg::fpu_result_t act);
    if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
      res_errs++;
      $display("ERROR result: expected %h, actual %h", exp, act);
    end
  endtask

  task automatic check_ret(input fpu_lane_pkg::fpu_ret_t exp, input fpu_lane_pkg::fpu_ret_t act);
    if (exp.en ? (act !== exp) : (act.en !== 1'b0)) begin
      ret_errs++;
      $display("ERROR ret: expected %h, actual %h", exp, act);
    end
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", max_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int i;
    res_errs = 0;
    ret_errs = 0;
    rst = 1'b1;
    issue = '0;
    reg_a = '0;
    reg_b = '0;
    fwd_a = {fpu_lane_pkg::fwd_none, fpu_lane_pkg::fwd_none};
    fwd_b = {fpu_lane_pkg::fwd_none, fpu_lane_pkg::fwd_none};
    csr = '0;
    for (i = 0; i < fpu_lane_pkg::num_buses; i++) begin
      res_bus[i] = pick_operand();
    end
    prev_bus = res_bus;
    repeat (reset_cycles) begin
      @(posedge clk);
      #1;
      check_result('0, result);
      check_ret('0, ret);
    end
    rst = 1'b0;
    // the two cycles after reset carry no op
    repeat (2) begin
      exp_res_q.push_back('0);
      exp_ret_q.push_back('0);
    end
    for (i = 0; i < num_ops + 2; i++) begin
      check_result(exp_res_q.pop_front(), result);
      check_ret(exp_ret_q.pop_front(), ret);
      prev_bus = res_bus;
      drive_inputs(i < num_ops);
      predict();
      @(posedge clk);
      #1;
    end
    $display("result errors: %0d, ret errors: %0d", res_errs, ret_errs);
    if (res_errs + ret_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== fpu_lane.f ====
hw/fpu_lane_pkg.sv
hw/operand_forward.sv
hw/fpu_op_decode.sv
hw/fp_compare.sv
hw/fp_perm_logic.sv
hw/fpu_except.sv
hw/fpu_lane.sv
dv/fpu_lane_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f fpu_lane.f \
  --top-module fpu_lane_tb -o sim_fpu_lane
out=$(./obj_dir/sim_fpu_lane)
echo "$out"
if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
else
  exit 1
fi
